/* src.f */
+incdir+.
load_pkg.sv
mem_pkg.sv
addr_unit.sv
load_buffer.sv
data_ctrl.sv
load_subsystem_top.sv
tb_load_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load subsystem testbench, result decided from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_load_subsystem \
	-o sim_load_subsystem \
	&& ./obj_dir/sim_load_subsystem 2>&1 | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }

grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0

/* tb_load_subsystem.sv */
`timescale 1ns/100ps

`include "lsu_defines.svh"

module tb_load_subsystem import load_pkg::*, mem_pkg::*;;

	localparam int LIVE_MAX  = `LB_COUNT - 1;
	localparam int TAG_COUNT = 2**`ROB_WIDTH;

	logic                 clk_in;
	logic                 rob_lbuffer_rst_in;
	logic                 issue_en;
	load_issue_t          issue;
	logic                 alloc_en;
	rob_alloc_t           alloc;
	logic                 slot_free;
	logic                 ready_en;
	logic [`LB_WIDTH-1:0] ready_slot;
	logic                 result_en;
	load_result_t         result;
	logic                 wr_en;
	mem_wr_t              wr;

	integer                 seed = 32'h4f97;
	int                     errors = 0;
	int                     tests = 0;
	int                     failed_tests = 0;
	int                     test_start_errors;
	int                     outstanding = 0;
	logic [`DATA_WIDTH-1:0] shadow [2**`MEM_DEPTH_LOG2];
	// scoreboard keyed by rob tag
	logic [TAG_COUNT-1:0]   exp_valid = '0;
	load_result_t           exp_res [TAG_COUNT];
	logic [`LB_WIDTH-1:0]   tag_slot [TAG_COUNT];
	logic [`LB_COUNT-1:0]   slot_live = '0;
	logic [`ROB_WIDTH-1:0]  next_tag = '0;
	logic [`ROB_WIDTH-1:0]  alloc_tags [$];
	logic [`LB_WIDTH-1:0]   grant_pool [$];
	load_op_t               ops [5] = '{LOAD_LB, LOAD_LH, LOAD_LW, LOAD_LBU, LOAD_LHU};

	load_subsystem_top i_dut (
		.clk_in             (clk_in),
		.rob_lbuffer_rst_in (rob_lbuffer_rst_in),
		.issue_en           (issue_en),
		.issue              (issue),
		.alloc_en           (alloc_en),
		.alloc              (alloc),
		.slot_free          (slot_free),
		.ready_en           (ready_en),
		.ready_slot         (ready_slot),
		.result_en          (result_en),
		.result             (result),
		.wr_en              (wr_en),
		.wr                 (wr)
	);

	initial clk_in = 1'b0;

	always #5 clk_in = ~clk_in;

	// expected load data by the RV32I extension rules
	function automatic logic [`DATA_WIDTH-1:0] expect_data(input logic [31:0] word,
			input logic [1:0] off, input load_op_t op);
		logic [7:0]  b;
		logic [15:0] h;
		b = 8'(word >> (off * 8));
		h = 16'(word >> (off[1] * 16));
		case (op)
			LOAD_LB:  return {{24{b[7]}}, b};
			LOAD_LBU: return {24'd0, b};
			LOAD_LH:  return {{16{h[15]}}, h};
			LOAD_LHU: return {16'd0, h};
			default:  return word;
		endcase
	endfunction

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic check_result(input load_result_t exp, input load_result_t got);
		if (got !== exp) begin
			$display("** Error: result expected dest %h data %h, got dest %h data %h",
				exp.dest, exp.data, got.dest, got.data);
			errors++;
		end
	endtask

	task automatic check_alloc(input rob_alloc_t got, input logic [`ROB_WIDTH-1:0] exp_tag);
		if (got.rob_tag !== exp_tag) begin
			$display("** Error: alloc.rob_tag expected %h got %h", exp_tag, got.rob_tag);
			errors++;
		end
		if (got.slot == '0) begin
			$display("** Error: alloc.slot expected nonzero got %h", got.slot);
			errors++;
		end else if (slot_live[got.slot]) begin
			$display("alloc named slot %0d, which a live load still holds", got.slot);
			errors++;
		end
	endtask

	// rob side monitor that handles results before allocations
	always @(posedge clk_in) begin
		if (result_en) begin
			if (!exp_valid[result.dest]) begin
				$display("result_en for tag %0d, which has no load in flight", result.dest);
				errors++;
			end else begin
				check_result(exp_res[result.dest], result);
				exp_valid[result.dest] = 1'b0;
				slot_live[tag_slot[result.dest]] = 1'b0;
				outstanding--;
			end
		end
		if (alloc_en) begin
			if (alloc_tags.size() == 0) begin
				$display("alloc_en arrived with no issued load waiting for it");
				errors++;
			end else begin
				check_alloc(alloc, alloc_tags[0]);
				tag_slot[alloc_tags.pop_front()] = alloc.slot;
				slot_live[alloc.slot] = 1'b1;
				grant_pool.push_back(alloc.slot);
			end
		end
	end

	task automatic cycle();
		@(negedge clk_in);
		issue_en = 1'b0;
		ready_en = 1'b0;
		wr_en    = 1'b0;
	endtask

	task automatic clear_tracking();
		exp_valid   = '0;
		slot_live   = '0;
		outstanding = 0;
		alloc_tags.delete();
		grant_pool.delete();
	endtask

	task automatic apply_reset(input int n);
		rob_lbuffer_rst_in = 1'b1;
		clear_tracking();
		repeat (n) cycle();
		rob_lbuffer_rst_in = 1'b0;
	endtask

	// caller makes sure a slot is free and calls this right after cycle()
	task automatic issue_load(input logic [7:0] word_addr, input logic [1:0] off,
			input load_op_t op);
		logic [`ROB_WIDTH-1:0] tag;
		logic [31:0]           addr;
		if (!slot_free) begin
			$display("slot_free low although fewer than %0d loads are live", LIVE_MAX);
			errors++;
		end
		tag = next_tag;
		for (int k = 0; k < TAG_COUNT && exp_valid[tag]; k++) begin
			tag++;
		end
		next_tag = tag + 1'b1;
		addr = {22'd0, word_addr, off};
		issue.offset = $random(seed);
		issue.base   = addr - issue.offset;
		issue.dest   = tag;
		issue.op     = op;
		issue_en     = 1'b1;
		exp_res[tag] = '{dest: tag, data: expect_data(shadow[word_addr], off, op)};
		exp_valid[tag] = 1'b1;
		alloc_tags.push_back(tag);
		outstanding++;
	endtask

	task automatic random_load();
		load_op_t   op;
		logic [1:0] off;
		op  = ops[rand_below(5)];
		off = 2'(rand_below(4));
		if (op == LOAD_LW) begin
			off = 2'd0;
		end else if (op == LOAD_LH || op == LOAD_LHU) begin
			off[0] = 1'b0;
		end
		issue_load(8'(rand_below(256)), off, op);
	endtask

	task automatic grant_random();
		int idx;
		idx        = rand_below(grant_pool.size());
		ready_slot = grant_pool[idx];
		ready_en   = 1'b1;
		grant_pool.delete(idx);
	endtask

	task automatic wait_allocs(input int n);
		int waited;
		waited = 0;
		while (grant_pool.size() < n && waited < 50) begin
			cycle();
			waited++;
		end
		if (grant_pool.size() < n) begin
			$display("timeout: only %0d of %0d allocations seen", grant_pool.size(), n);
			errors++;
		end
	endtask

	// grant in random order until every live load has completed
	task automatic drain(input int limit);
		int waited;
		waited = 0;
		while (outstanding != 0 && waited < limit) begin
			cycle();
			if (grant_pool.size() != 0) begin
				grant_random();
			end
			waited++;
		end
		if (outstanding != 0) begin
			$display("timeout: %0d loads never completed", outstanding);
			errors++;
		end
		cycle();
	endtask

	task automatic begin_test();
		test_start_errors = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors) begin
			$display("test %-16s passed", name);
		end else begin
			$display("test %-16s failed with %0d errors", name, errors - test_start_errors);
			failed_tests++;
		end
	endtask

	initial begin
		int waited;
		int issued;
		rob_lbuffer_rst_in = 1'b1;
		issue_en   = 1'b0;
		issue      = '0;
		ready_en   = 1'b0;
		ready_slot = '0;
		wr_en      = 1'b0;
		wr         = '0;
		apply_reset(16);

		for (int w = 0; w < 2**`MEM_DEPTH_LOG2; w++) begin
			cycle();
			wr.addr   = `MEM_DEPTH_LOG2'(w);
			wr.data   = $random(seed);
			wr_en     = 1'b1;
			shadow[w] = wr.data;
		end
		cycle();

		// every opcode at every legal byte offset
		begin_test();
		foreach (ops[i]) begin
			for (int off = 0; off < 4; off++) begin
				if (ops[i] == LOAD_LW && off != 0) continue;
				if ((ops[i] == LOAD_LH || ops[i] == LOAD_LHU) && off[0]) continue;
				cycle();
				issue_load(8'(rand_below(256)), 2'(off), ops[i]);
				drain(100);
			end
		end
		end_test("alloc_and_widths");

		begin_test();
		for (int i = 0; i < LIVE_MAX; i++) begin
			cycle();
			issue_load(8'(rand_below(256)), 2'd0, LOAD_LW);
		end
		waited = 0;
		while (slot_free && waited < 20) begin
			cycle();
			waited++;
		end
		if (slot_free) begin
			$display("slot_free stayed high with seven loads held");
			errors++;
		end
		wait_allocs(LIVE_MAX);
		cycle();
		grant_random();
		waited = 0;
		while (outstanding > LIVE_MAX - 1 && waited < 50) begin
			cycle();
			waited++;
		end
		cycle();
		if (!slot_free) begin
			$display("slot_free still low after one load completed");
			errors++;
		end
		drain(200);
		end_test("full_buffer");

		begin_test();
		for (int i = 0; i < LIVE_MAX; i++) begin
			cycle();
			random_load();
		end
		wait_allocs(LIVE_MAX);
		drain(200);
		end_test("random_grants");

		// flush with granted and waiting loads and reuse the buffer afterwards
		begin_test();
		for (int i = 0; i < 5; i++) begin
			cycle();
			random_load();
		end
		wait_allocs(5);
		cycle();
		grant_random();
		cycle();
		grant_random();
		repeat (2) cycle();
		apply_reset(3);
		repeat (20) cycle();
		if (!slot_free) begin
			$display("slot_free low after the flush");
			errors++;
		end
		for (int i = 0; i < 3; i++) begin
			cycle();
			random_load();
		end
		drain(200);
		end_test("flush");

		begin_test();
		issued = 0;
		waited = 0;
		while ((issued < 200 || outstanding != 0) && waited < 20000) begin
			cycle();
			if (issued < 200 && outstanding < LIVE_MAX && slot_free && rand_below(2) == 0) begin
				random_load();
				issued++;
			end
			if (grant_pool.size() != 0 && rand_below(3) == 0) begin
				grant_random();
			end
			waited++;
		end
		if (issued < 200 || outstanding != 0) begin
			$display("timeout: random traffic stalled, %0d issued, %0d live", issued, outstanding);
			errors++;
		end
		if (exp_valid != '0) begin
			$display("scoreboard not empty at the end, tags %h", exp_valid);
			errors++;
		end
		end_test("random_traffic");

		$display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* load_subsystem_top.sv */
`timescale 1ns/100ps

`include "lsu_defines.svh"

module load_subsystem_top import load_pkg::*, mem_pkg::*; (
	input  logic                 clk_in,
	input  logic                 rob_lbuffer_rst_in,

	// issue from the reservation station
	input  logic                 issue_en,
	input  load_issue_t          issue,

	// rob side
	output logic                 alloc_en,
	output rob_alloc_t           alloc,
	output logic                 slot_free,
	input  logic                 ready_en,
	input  logic [`LB_WIDTH-1:0] ready_slot,
	output logic                 result_en,
	output load_result_t         result,

	// memory preload
	input  logic                 wr_en,
	input  mem_wr_t              wr
);

	logic                   entry_en;
	load_entry_t            entry;
	logic                   req_en;
	mem_req_t               req;
	logic                   rsp_en;
	logic [`DATA_WIDTH-1:0] rsp_data;

	addr_unit i_addr_unit (
		.clk_in             (clk_in),
		.rob_lbuffer_rst_in (rob_lbuffer_rst_in),
		.issue_en           (issue_en),
		.issue              (issue),
		.entry_en           (entry_en),
		.entry              (entry)
	);

	load_buffer i_load_buffer (
		.clk_in             (clk_in),
		.rob_lbuffer_rst_in (rob_lbuffer_rst_in),
		.entry_en           (entry_en),
		.entry              (entry),
		.alloc_en           (alloc_en),
		.alloc              (alloc),
		.slot_free          (slot_free),
		.ready_en           (ready_en),
		.ready_slot         (ready_slot),
		.result_en          (result_en),
		.result             (result),
		.req_en             (req_en),
		.req                (req),
		.rsp_en             (rsp_en),
		.rsp_data           (rsp_data)
	);

	data_ctrl i_data_ctrl (
		.clk_in             (clk_in),
		.rob_lbuffer_rst_in (rob_lbuffer_rst_in),
		.wr_en              (wr_en),
		.wr                 (wr),
		.req_en             (req_en),
		.req                (req),
		.rsp_en             (rsp_en),
		.rsp_data           (rsp_data)
	);

endmodule

/* data_ctrl.sv */
`timescale 1ns/100ps

`include "lsu_defines.svh"

module data_ctrl import mem_pkg::*; (
	input  logic                   clk_in,
	input  logic                   rob_lbuffer_rst_in,

	// preload port
	input  logic                   wr_en,
	input  mem_wr_t                wr,

	// from and to the load buffer
	input  logic                   req_en,
	input  mem_req_t               req,
	output logic                   rsp_en,
	output logic [`DATA_WIDTH-1:0] rsp_data
);

	localparam int LAST = `MEM_LATENCY - 1;

	logic [`DATA_WIDTH-1:0]  mem_array [2**`MEM_DEPTH_LOG2];
	logic [`MEM_LATENCY-1:0] pipe_vld;
	mem_req_t                pipe_req [`MEM_LATENCY];
	mem_req_t                out_req;
	mem_word_u               rd_word;
	logic [1:0]              byte_off;
	logic [7:0]              rd_byte;
	logic [15:0]             rd_half;

	always_ff @(posedge clk_in) begin
		if (wr_en) begin
			mem_array[wr.addr] <= wr.data;
		end
	end

	// request pipeline, a flush discards reads in flight
	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in) begin
			pipe_vld <= '0;
		end else begin
			pipe_vld[0] <= req_en;
			for (int i = 1; i < `MEM_LATENCY; i++) begin
				pipe_vld[i] <= pipe_vld[i-1];
			end
		end
	end

	always_ff @(posedge clk_in) begin
		pipe_req[0] <= req;
		for (int i = 1; i < `MEM_LATENCY; i++) begin
			pipe_req[i] <= pipe_req[i-1];
		end
	end

	assign out_req      = pipe_req[LAST];
	assign byte_off     = out_req.addr[1:0];
	assign rd_word.word = mem_array[out_req.addr[`MEM_DEPTH_LOG2+1:2]];
	assign rd_byte      = rd_word.bytes[byte_off];
	// halfword pair picked by address bit 1
	assign rd_half      = {rd_word.bytes[{byte_off[1], 1'b1}], rd_word.bytes[{byte_off[1], 1'b0}]};
	assign rsp_en       = pipe_vld[LAST];

	always_comb begin
		case (out_req.width)
			MEM_WIDTH_BYTE: rsp_data = {{(`DATA_WIDTH-8){out_req.sgn & rd_byte[7]}}, rd_byte};
			MEM_WIDTH_HALF: rsp_data = {{(`DATA_WIDTH-16){out_req.sgn & rd_half[15]}}, rd_half};
			default:        rsp_data = rd_word.word;
		endcase
	end

endmodule

/* load_buffer.sv */
`timescale 1ns/100ps

`include "lsu_defines.svh"

module load_buffer import load_pkg::*, mem_pkg::*; (
	input  logic                   clk_in,
	input  logic                   rob_lbuffer_rst_in,

	// from the address unit
	input  logic                   entry_en,
	input  load_entry_t            entry,

	// rob side
	output logic                   alloc_en,
	output rob_alloc_t             alloc,
	output logic                   slot_free,
	input  logic                   ready_en,
	input  logic [`LB_WIDTH-1:0]   ready_slot,
	output logic                   result_en,
	output load_result_t           result,

	// data controller side
	output logic                   req_en,
	output mem_req_t               req,
	input  logic                   rsp_en,
	input  logic [`DATA_WIDTH-1:0] rsp_data
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQ,
		SEQ_WAIT
	} seq_state_t;

	logic [`LB_COUNT-1:0] busy;
	logic [`LB_COUNT-1:0] ready;
	load_entry_t          slot_entry [`LB_COUNT];
	logic [`LB_WIDTH-1:0] free_next [`LB_COUNT];
	logic [`LB_WIDTH-1:0] free_head;
	logic [`LB_WIDTH-1:0] head_popped;
	logic [`LB_WIDTH-1:0] pick_slot;
	logic [`LB_WIDTH-1:0] cur_slot;
	logic                 alloc_ok;
	logic                 done;
	seq_state_t           state;

	// opcode to access width and sign
	function automatic mem_req_t make_req(load_entry_t e);
		mem_req_t r;
		r.addr = e.addr;
		case (e.op)
			LOAD_LB: begin
				r.width = MEM_WIDTH_BYTE;
				r.sgn   = 1'b1;
			end
			LOAD_LH: begin
				r.width = MEM_WIDTH_HALF;
				r.sgn   = 1'b1;
			end
			LOAD_LBU: begin
				r.width = MEM_WIDTH_BYTE;
				r.sgn   = 1'b0;
			end
			LOAD_LHU: begin
				r.width = MEM_WIDTH_HALF;
				r.sgn   = 1'b0;
			end
			default: begin
				r.width = MEM_WIDTH_WORD;
				r.sgn   = 1'b0;
			end
		endcase
		return r;
	endfunction

	// head 0 means the list is empty
	assign slot_free   = (free_head != '0);
	assign alloc_ok    = entry_en && slot_free;
	assign head_popped = alloc_ok ? free_next[free_head] : free_head;

	// highest-index slot that is busy and granted
	always_comb begin
		pick_slot = '0;
		for (int i = 1; i < `LB_COUNT; i++) begin
			if (busy[i] && ready[i]) begin
				pick_slot = `LB_WIDTH'(i);
			end
		end
	end

	assign req_en    = (state == SEQ_REQ);
	assign req       = make_req(slot_entry[cur_slot]);
	assign done      = (state == SEQ_WAIT) && rsp_en;
	assign result_en = done;
	assign result    = '{dest: slot_entry[cur_slot].dest, data: rsp_data};

	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in) begin
			free_head    <= `LB_WIDTH'(`LB_COUNT - 1);
			free_next[0] <= '0;
			for (int i = 1; i < `LB_COUNT; i++) begin
				free_next[i] <= `LB_WIDTH'(i - 1);
			end
			busy     <= '0;
			ready    <= '0;
			cur_slot <= '0;
			state    <= SEQ_IDLE;
			alloc_en <= 1'b0;
		end else begin
			alloc_en <= alloc_ok;
			// grants for idle slots are dropped here
			if (ready_en && busy[ready_slot]) begin
				ready[ready_slot] <= 1'b1;
			end
			if (alloc_ok) begin
				busy[free_head]  <= 1'b1;
				ready[free_head] <= 1'b0;
			end
			case (state)
				SEQ_IDLE: begin
					if (pick_slot != '0) begin
						cur_slot         <= pick_slot;
						ready[pick_slot] <= 1'b0;
						state            <= SEQ_REQ;
					end
				end
				SEQ_REQ: begin
					state <= SEQ_WAIT;
				end
				default: begin
					if (rsp_en) begin
						busy[cur_slot] <= 1'b0;
						state          <= SEQ_IDLE;
					end
				end
			endcase
			// completed slot goes back on top of the list
			if (done) begin
				free_next[cur_slot] <= head_popped;
				free_head           <= cur_slot;
			end else begin
				free_head <= head_popped;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (alloc_ok) begin
			slot_entry[free_head] <= entry;
			alloc.rob_tag         <= entry.dest;
			alloc.slot            <= free_head;
		end
	end

endmodule

/* addr_unit.sv */
`timescale 1ns/100ps

`include "lsu_defines.svh"

module addr_unit import load_pkg::*; (
	input  logic        clk_in,
	input  logic        rob_lbuffer_rst_in,

	// from the reservation station
	input  logic        issue_en,
	input  load_issue_t issue,

	// to the load buffer
	output logic        entry_en,
	output load_entry_t entry
);

	logic [`ADDR_WIDTH-1:0] eff_addr;

	assign eff_addr = issue.base + issue.offset;

	// a flush drops an issue that is still in this stage
	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in) begin
			entry_en <= 1'b0;
		end else begin
			entry_en <= issue_en;
		end
	end

	always_ff @(posedge clk_in) begin
		if (issue_en) begin
			entry.addr <= eff_addr;
			entry.dest <= issue.dest;
			entry.op   <= issue.op;
		end
	end

endmodule

/* mem_pkg.sv */
`include "lsu_defines.svh"

package mem_pkg;

	// access width codes, one-hot in bytes
	localparam logic [2:0] MEM_WIDTH_BYTE = 3'b001;
	localparam logic [2:0] MEM_WIDTH_HALF = 3'b010;
	localparam logic [2:0] MEM_WIDTH_WORD = 3'b100;

	typedef struct packed {
		logic [`ADDR_WIDTH-1:0] addr;
		logic [2:0]             width;
		logic                   sgn;
	} mem_req_t;

	// preload write, addressed by word
	typedef struct packed {
		logic [`MEM_DEPTH_LOG2-1:0] addr;
		logic [`DATA_WIDTH-1:0]     data;
	} mem_wr_t;

	// one memory word, seen whole or as its bytes
	typedef union packed {
		logic [`DATA_WIDTH-1:0]          word;
		logic [`DATA_WIDTH/8-1:0][7:0]   bytes;
	} mem_word_u;

endpackage

/* load_pkg.sv */
`include "lsu_defines.svh"

package load_pkg;

	// funct3 encodings of the RV32I loads
	typedef enum logic [2:0] {
		LOAD_LB  = 3'b000,
		LOAD_LH  = 3'b001,
		LOAD_LW  = 3'b010,
		LOAD_LBU = 3'b100,
		LOAD_LHU = 3'b101
	} load_op_t;

	// load as issued by the reservation station
	typedef struct packed {
		logic [`ADDR_WIDTH-1:0] base;
		logic [`ADDR_WIDTH-1:0] offset;
		logic [`ROB_WIDTH-1:0]  dest;
		load_op_t               op;
	} load_issue_t;

	// load as held in a buffer slot
	typedef struct packed {
		logic [`ADDR_WIDTH-1:0] addr;
		logic [`ROB_WIDTH-1:0]  dest;
		load_op_t               op;
	} load_entry_t;

	// notice to the rob of where its load was placed
	typedef struct packed {
		logic [`ROB_WIDTH-1:0] rob_tag;
		logic [`LB_WIDTH-1:0]  slot;
	} rob_alloc_t;

	typedef struct packed {
		logic [`ROB_WIDTH-1:0]  dest;
		logic [`DATA_WIDTH-1:0] data;
	} load_result_t;

endpackage

/* lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// load buffer slots, slot 0 stands for "none"
`define LB_COUNT 8
`define LB_WIDTH 3

// reorder buffer tag bits
`define ROB_WIDTH 4

// datapath widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// word-addressed memory behind the data controller
`define MEM_DEPTH_LOG2 8

// cycles from req_en to rsp_en
`define MEM_LATENCY 2

`endif
